// ==== hdl/uart_autobaud.sv ====
`timescale 1ns/1ps

module uart_autobaud (
   input  logic       clk,
   input  logic       nRst,
   input  logic       transmit,
   input  logic       rx,
   input  logic [7:0] data_tx,
   output logic       busy_tx,
   output logic       received,
   output logic       tx,
   output logic [7:0] data_rx
);
   import up_pkg::*;

   typedef enum logic [2:0] {
      CAL_WAIT, CAL_MEASURE, RX_IDLE, RX_START, RX_DATA, RX_STOP
   } rx_state_t;

   rx_state_t         rx_state;
   logic [1:0]        rx_sync;
   logic              rx_in;
   logic [BAUD_W-1:0] period;
   logic [BAUD_W-1:0] rx_cnt;
   logic [2:0]        rx_bit;
   logic [7:0]        rx_sh;
   logic              rx_skip;
   logic              cal_done;
   logic [BAUD_W-1:0] tx_cnt;
   logic [3:0]        tx_left;
   logic [8:0]        tx_sh;

   assign rx_in    = rx_sync[1];
   assign cal_done = (rx_state != CAL_WAIT) && (rx_state != CAL_MEASURE);

   ////////////////////
   // receiver
   ////////////////////

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         rx_sync  <= 2'b11;
         rx_state <= CAL_WAIT;
         period   <= '0;
         rx_cnt   <= '0;
         rx_bit   <= 3'd0;
         rx_sh    <= 8'h00;
         rx_skip  <= 1'b0;
         received <= 1'b0;
         data_rx  <= 8'h00;
      end else begin
         rx_sync  <= {rx_sync[0], rx};
         received <= 1'b0;
         case (rx_state)
            CAL_WAIT: begin
               if (!rx_in) begin
                  rx_cnt   <= {{(BAUD_W-1){1'b0}}, 1'b1};
                  rx_state <= CAL_MEASURE;
               end
            end
            CAL_MEASURE: begin
               if (!rx_in) begin
                  rx_cnt <= rx_cnt + 1'b1;   // the sync start bit is one bit long.
               end else begin
                  period   <= rx_cnt;
                  rx_cnt   <= rx_cnt >> 1;   // line is now at the start of data bit 0.
                  rx_bit   <= 3'd0;
                  rx_skip  <= 1'b1;
                  rx_state <= RX_DATA;
               end
            end
            RX_IDLE: begin
               if (!rx_in) begin
                  rx_cnt   <= period >> 1;
                  rx_state <= RX_START;
               end
            end
            RX_START: begin
               if (rx_cnt == '0) begin
                  rx_cnt   <= period - 1'b1;
                  rx_bit   <= 3'd0;
                  rx_state <= rx_in ? RX_IDLE : RX_DATA;   // a short glitch is not a start.
               end else begin
                  rx_cnt <= rx_cnt - 1'b1;
               end
            end
            RX_DATA: begin
               if (rx_cnt == '0) begin
                  rx_cnt <= period - 1'b1;
                  rx_sh  <= {rx_in, rx_sh[7:1]};
                  rx_bit <= rx_bit + 3'd1;
                  if (rx_bit == 3'd7)
                     rx_state <= RX_STOP;
               end else begin
                  rx_cnt <= rx_cnt - 1'b1;
               end
            end
            RX_STOP: begin
               if (rx_cnt == '0) begin
                  if (rx_in && !rx_skip) begin
                     received <= 1'b1;
                     data_rx  <= rx_sh;
                  end
                  rx_skip  <= 1'b0;
                  rx_state <= RX_IDLE;
               end else begin
                  rx_cnt <= rx_cnt - 1'b1;
               end
            end
            default: rx_state <= CAL_WAIT;
         endcase
      end
   end

   ////////////////////
   // transmitter
   ////////////////////

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         busy_tx <= 1'b0;
         tx      <= 1'b1;
         tx_cnt  <= '0;
         tx_left <= 4'd0;
         tx_sh   <= 9'h1FF;
      end else if (!busy_tx) begin
         if (transmit && cal_done) begin
            busy_tx <= 1'b1;
            tx      <= 1'b0;
            tx_sh   <= {1'b1, data_tx};
            tx_left <= 4'd9;   // eight data bits and the stop bit.
            tx_cnt  <= period - 1'b1;
         end
      end else if (tx_cnt != '0) begin
         tx_cnt <= tx_cnt - 1'b1;
      end else begin
         tx_cnt <= period - 1'b1;
         if (tx_left == 4'd0) begin
            busy_tx <= 1'b0;
         end else begin
            tx      <= tx_sh[0];
            tx_sh   <= {1'b1, tx_sh[8:1]};
            tx_left <= tx_left - 4'd1;
         end
      end
   end

endmodule

// ==== hdl/up.sv ====
`timescale 1ns/1ps

module up (
   input  logic       clk,
   input  logic       nRst,
   input  logic       prog,
   input  logic       rx,
   output logic [7:0] led,
   output logic       tx
);

   logic       core_nrst;
   logic       ale;
   logic       mem_re;
   logic       mem_we;
   logic [7:0] data_in;
   logic [7:0] data_out;
   logic       transmit;
   logic [7:0] data_tx;
   logic       received;
   logic [7:0] data_rx;
   logic       busy_tx;

   up_ctrl_if ctl ();

   assign core_nrst = nRst & ~prog;   // the core stays idle while a program loads.

   up_datapath u_datapath (
      .clk      (clk       ),
      .nRst     (core_nrst ),
      .ctl      (ctl       ),
      .data_in  (data_in   ),
      .data_out (data_out  )
   );

   up_controller u_controller (
      .clk      (clk       ),
      .nRst     (core_nrst ),
      .ctl      (ctl       ),
      .ale      (ale       ),
      .mem_re   (mem_re    ),
      .mem_we   (mem_we    )
   );

   up_memory u_memory (
      .clk      (clk       ),
      .nRst     (nRst      ),
      .prog     (prog      ),
      .in       (data_out  ),
      .data_rx  (data_rx   ),
      .ale      (ale       ),
      .we       (mem_we    ),
      .re       (mem_re    ),
      .received (received  ),
      .busy_tx  (busy_tx   ),
      .out      (data_in   ),
      .data_tx  (data_tx   ),
      .leds     (led       ),
      .transmit (transmit  )
   );

   uart_autobaud u_uart (
      .clk      (clk       ),
      .nRst     (nRst      ),
      .transmit (transmit  ),
      .rx       (rx        ),
      .data_tx  (data_tx   ),
      .busy_tx  (busy_tx   ),
      .received (received  ),
      .tx       (tx        ),
      .data_rx  (data_rx   )
   );

endmodule

// ==== hdl/up_controller.sv ====
`timescale 1ns/1ps

module up_controller (
   input  logic          clk,
   input  logic          nRst,
   up_ctrl_if.controller ctl,
   output logic          ale,
   output logic          mem_re,
   output logic          mem_we
);
   import up_pkg::*;

   typedef enum logic [3:0] {
      IDLE, FETCH_ADDR, FETCH_READ, DECODE, OPD_ADDR, OPD_READ,
      MEM_ADDR, MEM_ACCESS, EXEC, HALT
   } state_t;

   state_t  state;
   state_t  state_nxt;
   opcode_t opc;

   assign opc        = ctl.ir.reg_v.opcode;
   assign ctl.rb_sel = ctl.ir.reg_v.rsel;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt  = state;
      ctl.op     = NONE;
      ctl.ir_we  = 1'b0;
      ctl.opd_we = 1'b0;
      ctl.pc_we  = 1'b0;
      ctl.rb_we  = 1'b0;
      ale        = 1'b0;
      mem_re     = 1'b0;
      mem_we     = 1'b0;
      case (state)
         IDLE: state_nxt = FETCH_ADDR;
         FETCH_ADDR: begin
            ctl.op    = PC_OUT;
            ctl.pc_we = 1'b1;
            ale       = 1'b1;
            state_nxt = FETCH_READ;
         end
         FETCH_READ: begin
            mem_re    = 1'b1;
            state_nxt = DECODE;
         end
         DECODE: begin
            ctl.ir_we = 1'b1;   // one-byte instructions execute in this cycle.
            state_nxt = FETCH_ADDR;
            case (opc)
               OP_LDI, OP_LD, OP_ST, OP_JMP, OP_JZ: state_nxt = OPD_ADDR;
               OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI: begin
                  ctl.op    = ALU_EXEC;
                  ctl.rb_we = 1'b1;
               end
               OP_MOV, OP_MVA: begin
                  ctl.op    = MOVE;
                  ctl.rb_we = 1'b1;
               end
               OP_HALT: state_nxt = HALT;
               default: ;   // free codes act as no-ops.
            endcase
         end
         OPD_ADDR: begin
            ctl.op    = PC_OUT;
            ctl.pc_we = 1'b1;
            ale       = 1'b1;
            state_nxt = OPD_READ;
         end
         OPD_READ: begin
            mem_re    = 1'b1;
            state_nxt = (opc == OP_LD || opc == OP_ST) ? MEM_ADDR : EXEC;
         end
         MEM_ADDR: begin
            ctl.opd_we = 1'b1;
            ctl.op     = OPD_OUT;
            ale        = 1'b1;
            mem_re     = (opc == OP_LD);   // read goes out with the address.
            state_nxt  = MEM_ACCESS;
         end
         MEM_ACCESS: begin
            if (opc == OP_LD) begin
               ctl.op    = LOAD_REG;
               ctl.rb_we = 1'b1;
            end else begin
               ctl.op = REG_OUT;
               mem_we = 1'b1;
            end
            state_nxt = FETCH_ADDR;
         end
         EXEC: begin
            ctl.opd_we = 1'b1;
            case (opc)
               OP_LDI: begin
                  ctl.op    = LOAD_REG;
                  ctl.rb_we = 1'b1;
               end
               OP_JMP: begin
                  ctl.op    = OPD_OUT;
                  ctl.pc_we = 1'b1;
               end
               OP_JZ: begin
                  ctl.op    = OPD_OUT;
                  ctl.pc_we = ctl.z;
               end
               default: ;
            endcase
            state_nxt = FETCH_ADDR;
         end
         HALT: ;   // left only by the core reset.
         default: state_nxt = IDLE;
      endcase
   end

endmodule

// ==== hdl/up_ctrl_if.sv ====
`timescale 1ns/1ps

interface up_ctrl_if;
   import up_pkg::*;

   dp_op_t     op;
   logic       ir_we;
   logic       opd_we;
   logic       pc_we;
   logic       rb_we;
   logic [2:0] rb_sel;
   instr_t     ir;       // current instruction, bypassed while it is loaded.
   logic       z;

   modport controller (output op, ir_we, opd_we, pc_we, rb_we, rb_sel, input ir, z);
   modport datapath (input op, ir_we, opd_we, pc_we, rb_we, rb_sel, output ir, z);

endinterface

// ==== hdl/up_datapath.sv ====
`timescale 1ns/1ps

module up_datapath (
   input  logic        clk,
   input  logic        nRst,
   up_ctrl_if.datapath ctl,
   input  logic [7:0]  data_in,
   output logic [7:0]  data_out
);
   import up_pkg::*;

   logic [7:0] pc;
   instr_t     ir_q;
   instr_t     ir_cur;
   logic [7:0] opd_q;
   logic [7:0] opd_cur;
   logic [7:0] regs [NUM_REGS];
   logic [7:0] rb;
   logic [7:0] alu_y;
   logic [2:0] wr_sel;
   logic [7:0] wr_data;
   logic       z_q;

   assign ir_cur  = ctl.ir_we ? instr_t'(data_in) : ir_q;   // a byte is usable as it arrives.
   assign opd_cur = ctl.opd_we ? data_in : opd_q;
   assign rb      = regs[ctl.rb_sel];
   assign ctl.ir  = ir_cur;
   assign ctl.z   = z_q;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc   <= 8'h00;
         ir_q <= '0;
         z_q  <= 1'b0;
      end else begin
         if (ctl.pc_we) begin
            if (ctl.op == OPD_OUT)
               pc <= opd_cur;   // jump target.
            else
               pc <= pc + 8'd1;
         end
         if (ctl.ir_we)
            ir_q <= ir_cur;
         if (ctl.op == ALU_EXEC)
            z_q <= (alu_y == 8'h00);
      end
   end

   always_ff @(posedge clk) begin
      if (ctl.opd_we)
         opd_q <= data_in;
      if (ctl.rb_we)
         regs[wr_sel] <= wr_data;
   end

   always_comb begin
      case (ir_cur.reg_v.opcode)
         OP_ADD:  alu_y = regs[0] + rb;
         OP_SUB:  alu_y = regs[0] - rb;
         OP_AND:  alu_y = regs[0] & rb;
         OP_OR:   alu_y = regs[0] | rb;
         OP_XOR:  alu_y = regs[0] ^ rb;
         OP_ADDI: alu_y = regs[0] + {4'h0, ir_cur.imm_v.imm};
         default: alu_y = regs[0];
      endcase
   end

   always_comb begin
      wr_sel  = ctl.rb_sel;
      wr_data = data_in;   // load from memory or immediate.
      case (ctl.op)
         ALU_EXEC: begin
            wr_sel  = 3'd0;
            wr_data = alu_y;
         end
         MOVE: begin
            if (ir_cur.reg_v.opcode == OP_MVA) begin
               wr_sel  = 3'd0;
               wr_data = rb;
            end else begin
               wr_data = regs[0];
            end
         end
         default: ;
      endcase
   end

   always_comb begin
      case (ctl.op)
         PC_OUT:  data_out = pc;
         OPD_OUT: data_out = opd_cur;
         REG_OUT: data_out = rb;
         default: data_out = regs[0];
      endcase
   end

endmodule

// ==== hdl/up_memory.sv ====
`timescale 1ns/1ps

module up_memory (
   input  logic       clk,
   input  logic       nRst,
   input  logic       prog,
   input  logic [7:0] in,
   input  logic [7:0] data_rx,
   input  logic       ale,
   input  logic       we,
   input  logic       re,
   input  logic       received,
   input  logic       busy_tx,
   output logic [7:0] out,
   output logic [7:0] data_tx,
   output logic [7:0] leds,
   output logic       transmit
);
   import up_pkg::*;

   logic [7:0] ram [256];
   logic [7:0] addr_q;
   logic [7:0] rd_addr;
   logic [7:0] load_addr;
   logic [7:0] rx_byte;
   logic       wr_pend;
   logic       load_fresh;
   logic       prog_q;
   logic       io_wr;

   assign rd_addr = ale ? in : addr_q;
   assign io_wr   = we && (addr_q == ADDR_LED || addr_q == ADDR_UART);

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         addr_q     <= 8'h00;
         leds       <= 8'h00;
         transmit   <= 1'b0;
         prog_q     <= 1'b0;
         load_fresh <= 1'b1;
         wr_pend    <= 1'b0;
         load_addr  <= 8'h00;
      end else begin
         prog_q   <= prog;
         wr_pend  <= 1'b0;
         transmit <= we && (addr_q == ADDR_UART);
         if (ale)
            addr_q <= in;
         if (we && addr_q == ADDR_LED)
            leds <= in;
         if (prog && !prog_q)
            load_fresh <= 1'b1;
         if (wr_pend)
            load_addr <= load_addr + 8'd1;
         if (prog && received) begin
            wr_pend <= !(load_fresh && data_rx == SYNC_BYTE);   // a resent sync is dropped.
            if (load_fresh) begin
               load_fresh <= 1'b0;
               load_addr  <= 8'h00;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (received)
         rx_byte <= data_rx;
      if (we)
         data_tx <= in;
      if (wr_pend)
         ram[load_addr] <= rx_byte;
      else if (we && !io_wr)
         ram[addr_q] <= in;
      if (re) begin
         if (rd_addr == ADDR_UART)
            out <= {7'h00, busy_tx};
         else if (rd_addr == ADDR_LED)
            out <= leds;
         else
            out <= ram[rd_addr];
      end
   end

endmodule

// ==== hdl/up_pkg.sv ====
package up_pkg;

   ////////////////////
   // instruction set
   ////////////////////

   // code 4'h5 is left free, so a program never starts with the sync byte.
   typedef enum logic [3:0] {
      OP_LDI  = 4'h0,
      OP_LD   = 4'h1,
      OP_ST   = 4'h2,
      OP_JMP  = 4'h3,
      OP_JZ   = 4'h4,
      OP_ADD  = 4'h6,
      OP_SUB  = 4'h7,
      OP_AND  = 4'h8,
      OP_OR   = 4'h9,
      OP_XOR  = 4'hA,
      OP_MOV  = 4'hB,   // register takes r0.
      OP_MVA  = 4'hC,   // r0 takes register.
      OP_ADDI = 4'hD,
      OP_HALT = 4'hF
   } opcode_t;

   typedef struct packed {
      opcode_t    opcode;
      logic       spare;
      logic [2:0] rsel;
   } instr_reg_t;

   typedef struct packed {
      opcode_t    opcode;
      logic [3:0] imm;
   } instr_imm_t;

   typedef union packed {
      instr_reg_t reg_v;
      instr_imm_t imm_v;
   } instr_t;

   typedef enum logic [2:0] {
      NONE, PC_OUT, OPD_OUT, REG_OUT, ALU_EXEC, LOAD_REG, MOVE
   } dp_op_t;

   ////////////////////
   // memory map, uart
   ////////////////////

   localparam logic [7:0] ADDR_LED  = 8'hFE;
   localparam logic [7:0] ADDR_UART = 8'hFF;
   localparam logic [7:0] SYNC_BYTE = 8'h55;
   localparam int         BAUD_W    = 12;
   localparam int         NUM_REGS  = 8;

endpackage

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir build.log sim.log
verilator --binary --timing --top-module up_tb -f verilog.f -o up_sim > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/up_sim > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log && exit 0 || exit 1

// ==== test/up_tb_programs.svh ====
`ifndef UP_TB_PROGRAMS_SVH
`define UP_TB_PROGRAMS_SVH

localparam int NUM_TESTS  = 9;
localparam int CODE_BYTES = 109;

localparam logic [1:0] KIND_PLAIN = 2'd0;
localparam logic [1:0] KIND_LFSR  = 2'd1;   // bytes 1 and 3 take random operands.
localparam logic [1:0] KIND_TX    = 2'd2;
localparam logic [1:0] KIND_STOP  = 2'd3;   // prog rises while the program still runs.

localparam logic [63:0] TEST_NAME [NUM_TESTS] = '{
   "load_run", "alu_ops ", "modulo  ", "lfsr_add", "zero_jz ",
   "ram_mov ", "uart_tx ", "reload_a", "reload_b"
};
localparam int CODE_LEN [NUM_TESTS] = '{5, 17, 9, 8, 19, 13, 16, 16, 6};
localparam logic [1:0] KIND [NUM_TESTS] = '{
   KIND_PLAIN, KIND_PLAIN, KIND_PLAIN, KIND_LFSR, KIND_PLAIN,
   KIND_PLAIN, KIND_TX, KIND_STOP, KIND_PLAIN
};
localparam logic [7:0] EXP_LED [NUM_TESTS] = '{   // the lfsr entry is worked out at run time.
   8'hA5, 8'h5C, 8'hFF, 8'h00, 8'h06, 8'h96, 8'h5A, 8'h3C, 8'h77
};
localparam logic [7:0] EXP_TX [NUM_TESTS] = '{
   8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'hC3, 8'h00, 8'h00
};

localparam logic [7:0] CODE [CODE_BYTES] = '{
   8'h02, 8'hA5, 8'h22, 8'hFE, 8'hF0,
   8'h00, 8'h3C, 8'h01, 8'h0F, 8'h02, 8'hA0, 8'h03, 8'hF3,
   8'h61, 8'hA2, 8'h83, 8'h91, 8'h72, 8'hDD, 8'h20, 8'hFE, 8'hF0,   // 3C+0F^A0&F3|0F-A0+D.
   8'h00, 8'h10, 8'h01, 8'h20, 8'h71, 8'hDF, 8'h20, 8'hFE, 8'hF0,   // 10-20 wraps to F0.
   8'h00, 8'h00, 8'h01, 8'h00, 8'h61, 8'h20, 8'hFE, 8'hF0,
   8'h04, 8'h06, 8'h01, 8'h01, 8'h02, 8'h00, 8'hC2, 8'hD1, 8'hB2, 8'hC4,
   8'h71, 8'hB4, 8'h40, 8'h10, 8'h30, 8'h06, 8'h22, 8'hFE, 8'hF0,   // six passes of the loop.
   8'h03, 8'h96, 8'h23, 8'h80, 8'h03, 8'h00, 8'h15, 8'h80,
   8'hC5, 8'hB6, 8'h26, 8'hFE, 8'hF0,
   8'h01, 8'hC3, 8'h10, 8'hFF, 8'hD0, 8'h40, 8'h09, 8'h30,
   8'h02, 8'h21, 8'hFF, 8'h02, 8'h5A, 8'h22, 8'hFE, 8'hF0,
   8'h01, 8'h3C, 8'h21, 8'hFE, 8'h00, 8'hC0, 8'hD1, 8'h40,
   8'h0B, 8'h30, 8'h06, 8'h02, 8'hC3, 8'h22, 8'hFE, 8'hF0,   // C3 follows after a delay.
   8'h00, 8'h70, 8'hD7, 8'h20, 8'hFE, 8'hF0
};

`endif

// ==== test/up_tb.sv ====
`timescale 1ns/1ps

module up_tb;
   import up_pkg::*;

   `include "up_tb_programs.svh"

   localparam int BIT_CLKS  = 16;     // host bit period in clocks.
   localparam int RUN_CLKS  = 2000;
   localparam int HOLD_CLKS = 1200;   // longer than the delay loop of reload_a.

   logic        clk;
   logic        nRst;
   logic        prog;
   logic        rx;
   logic [7:0]  led;
   logic        tx;
   logic [31:0] lfsr_state;
   logic [7:0]  prog_bytes [32];
   int          prog_len;
   logic [7:0]  exp_led;
   logic [7:0]  tx_bytes [$];
   int          errors;
   int          frame_errors = 0;
   int          cycles = 0;
   int          limit;

   up dut (
      .clk  (clk ),
      .nRst (nRst),
      .prog (prog),
      .rx   (rx  ),
      .led  (led ),
      .tx   (tx  )
   );

   ////////////////////
   // clock, watchdog
   ////////////////////

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= limit) begin
         $display("Error: the run did not finish within %0d cycles", limit);
         $display("TESTS FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic random_byte(output logic [7:0] b);
      for (int i = 0; i < 8; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         b[i] = lfsr_state[0];
      end
   endtask

   function automatic int timeout_limit();
      int total;
      total = 16;
      for (int t = 0; t < NUM_TESTS; t++)
         total += (CODE_LEN[t] + 1) * 10 * BIT_CLKS + 2000;
      return total;
   endfunction

   task automatic wait_clocks(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic send_byte(input logic [7:0] b);
      rx = 1'b0;
      wait_clocks(BIT_CLKS);
      for (int i = 0; i < 8; i++) begin
         rx = b[i];
         wait_clocks(BIT_CLKS);
      end
      rx = 1'b1;
      wait_clocks(BIT_CLKS);
   endtask

   task automatic build_program(input int t, input int start);
      logic [7:0] a;
      logic [7:0] b;
      prog_len = CODE_LEN[t];
      for (int j = 0; j < prog_len; j++)
         prog_bytes[j] = CODE[start + j];
      exp_led = EXP_LED[t];
      if (KIND[t] == KIND_LFSR) begin
         random_byte(a);
         random_byte(b);
         exp_led = a + b;
         // the sum has to change led, and the next entry has to change it again.
         while (exp_led == led || (t + 1 < NUM_TESTS && exp_led == EXP_LED[t + 1])) begin
            b       = b + 8'd1;
            exp_led = a + b;
         end
         prog_bytes[1] = a;
         prog_bytes[3] = b;
      end
   endtask

   task automatic load_program();
      prog = 1'b1;
      wait_clocks(8);
      send_byte(SYNC_BYTE);
      for (int j = 0; j < prog_len; j++)
         send_byte(prog_bytes[j]);
      wait_clocks(4);
      prog = 1'b0;
   endtask

   task automatic wait_led_change(input logic [7:0] old, output bit ok);
      int n;
      n = 0;
      while (led === old && n < RUN_CLKS) begin
         @(negedge clk);
         n++;
      end
      ok = (led !== old);
   endtask

   task automatic wait_tx_byte(output bit ok);
      int n;
      n = 0;
      while (tx_bytes.size() == 0 && n < 12 * BIT_CLKS) begin
         @(negedge clk);
         n++;
      end
      ok = (tx_bytes.size() != 0);
   endtask

   task automatic check_value(input string sig, input logic [7:0] got, input logic [7:0] want);
      assert (got === want) else begin
         $display("Error at %0t: %s = 8'h%02h, expected 8'h%02h", $time, sig, got, want);
         errors++;
      end
   endtask

   ////////////////////
   // tx decoder
   ////////////////////

   initial begin : tx_monitor
      logic [7:0] b;
      forever begin
         @(negedge clk);
         if (nRst === 1'b1 && tx === 1'b0) begin
            wait_clocks(BIT_CLKS / 2);   // middle of the start bit.
            for (int i = 0; i < 8; i++) begin
               wait_clocks(BIT_CLKS);
               b[i] = tx;
            end
            wait_clocks(BIT_CLKS);
            assert (tx === 1'b1) else begin
               $display("Error at %0t: the byte on tx has no stop bit", $time);
               frame_errors++;
            end
            tx_bytes.push_back(b);
         end
      end
   end

   initial begin : main
      int         start;
      int         err_before;
      int         passes;
      int         fails;
      bit         ok;
      logic [7:0] led_before;
      nRst       = 1'b0;
      prog       = 1'b0;
      rx         = 1'b1;
      errors     = 0;
      passes     = 0;
      fails      = 0;
      start      = 0;
      lfsr_state = 32'hff70;
      limit      = timeout_limit();
      wait_clocks(16);
      nRst = 1'b1;
      wait_clocks(4);
      for (int t = 0; t < NUM_TESTS; t++) begin
         err_before = errors + frame_errors;
         build_program(t, start);
         led_before = led;
         load_program();
         wait_led_change(led_before, ok);
         assert (ok) else begin
            $display("Error at %0t: the program never wrote to led", $time);
            errors++;
         end
         check_value("led", led, exp_led);
         if (KIND[t] == KIND_TX) begin
            wait_tx_byte(ok);
            assert (ok) else begin
               $display("Error at %0t: no byte arrived on tx", $time);
               errors++;
            end
            if (ok)
               check_value("tx", tx_bytes.pop_front(), EXP_TX[t]);
         end
         assert (tx_bytes.size() == 0) else begin
            $display("Error at %0t: tx sent a byte that no program asked for", $time);
            errors++;
         end
         if (KIND[t] == KIND_STOP) begin
            prog = 1'b1;   // the core halts, led keeps the first write.
            wait_clocks(HOLD_CLKS);
            check_value("led", led, exp_led);
         end
         if (errors + frame_errors == err_before) begin
            passes++;
            $display("test %0d %s pass", t, TEST_NAME[t]);
         end else begin
            fails++;
            $display("test %0d %s fail", t, TEST_NAME[t]);
         end
         start += CODE_LEN[t];
      end
      $display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS, passes, fails,
               errors + frame_errors);
      if (errors == 0 && frame_errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+test
hdl/up_pkg.sv
hdl/up_ctrl_if.sv
hdl/up_datapath.sv
hdl/up_controller.sv
hdl/up_memory.sv
hdl/uart_autobaud.sv
hdl/up.sv
test/up_tb.sv
